// File: ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Instruction word
`define INSTR_W 16

// Register, address, data and trap selects
`define SEL_W 3

// ALU operation, flag condition and minor opcode
`define ALUOP_W 4

// Sequencer state register
`define STATE_W 4

`endif

// File: ctrlPkg.sv
`include "ctrl_defines.svh"

package ctrlPkg;

  // Top three bits of the instruction
  typedef enum logic [2:0] {
    ALU16   = 3'd0,
    ALU8H   = 3'd1,
    ALU8L   = 3'd2,
    MEM     = 3'd3,
    JUMP    = 3'd4,
    RSV5    = 3'd5,
    RSV6    = 3'd6,
    SPECIAL = 3'd7
  } majorOp_e;

  // Minor codes under MEM; bit 11 picks the byte for immediate loads
  typedef enum logic [`ALUOP_W-1:0] {
    read16       = 4'd0,
    write16      = 4'd1,
    read8L       = 4'd2,
    write8L      = 4'd3,
    read8H       = 4'd4,
    write8H      = 4'd5,
    read8SignExt = 4'd6,
    loadImmSext  = 4'd7,
    loadImm8     = 4'd8,
    loadImm9     = 4'd9,
    loadImm10    = 4'd10,
    loadImm11    = 4'd11,
    loadImm12    = 4'd12,
    loadImm13    = 4'd13,
    loadImm14    = 4'd14,
    loadImm15    = 4'd15
  } memOp_e;

  typedef enum logic [`STATE_W-1:0] {
    fetch      = 4'd0,
    execute    = 4'd1,
    callTarget = 4'd8,
    popPc      = 4'd9,
    popPcReti  = 4'd10,
    popFlags   = 4'd11,
    pushPc     = 4'd12,
    vectorSel  = 4'd13,
    vectorLoad = 4'd14,
    irqCheck   = 4'd15
  } seqState_e;

  // Where execute goes after the current cycle
  typedef enum logic [2:0] {
    stay,
    finish,
    toCallTarget,
    toPopPc,
    toPopPcReti
  } execNext_e;

  typedef struct packed {
    logic                ldIr;
    logic                ldSp;
    logic                incSp;
    logic                decSp;
    logic                ldPc;
    logic                incPc;
    logic                rd16;
    logic                rd8;
    logic [1:0]          wr;       // High byte, low byte
    logic [`SEL_W-1:0]   addrSel;
    logic [`SEL_W-1:0]   dataSel;
    logic [`SEL_W-1:0]   trapSel;
    logic [`SEL_W-1:0]   ra;
    logic [`SEL_W-1:0]   rb;
    logic [`SEL_W-1:0]   rd;
    logic [`SEL_W-1:0]   wd;
    logic [`ALUOP_W-1:0] aluop;
    logic [`ALUOP_W-1:0] flagCond;
    logic                flagSave;
    logic                flagRest;
    logic                op8;
  } ctrlWord_t;

  typedef struct packed {
    logic trap;
    logic nmi;
    logic intr;
  } irqLines_t;

endpackage

// File: execDecoder.sv
`include "ctrl_defines.svh"

module execDecoder (
  input  logic [`INSTR_W-1:0] ir,
  input  logic                status,
  input  logic                done,
  output ctrlPkg::ctrlWord_t  execWord,
  output ctrlPkg::execNext_e  execNext,
  output logic                setIrqEn,
  output logic                irqEnValue
);
  import ctrlPkg::*;

  majorOp_e             majorOp;
  memOp_e               memOp;
  logic [`ALUOP_W-1:0]  minorOp;
  logic                 regTarget;

  assign majorOp   = majorOp_e'(ir[`INSTR_W-1 -: 3]);
  assign minorOp   = ir[`INSTR_W-4 -: `ALUOP_W];
  assign memOp     = memOp_e'(minorOp);
  assign regTarget = &minorOp;  // All-ones minor op selects a register target

  // Bus cycles stay in execute until the memory answers
  function automatic execNext_e holdUntil(input logic ready, input execNext_e after);
    return ready ? after : stay;
  endfunction

  always_comb begin
    execWord   = '0;
    execNext   = finish;
    setIrqEn   = 1'b0;
    irqEnValue = 1'b0;
    case (majorOp)
      ALU16, ALU8H, ALU8L: begin
        execWord.flagSave = 1'b1;
        execWord.dataSel  = 3'd1;   // ALU result
        execWord.aluop    = minorOp;
        execWord.ra       = ir[8:6];
        execWord.rb       = ir[5:3];
        execWord.rd       = ir[2:0];
        case (majorOp)
          ALU16:   execWord.wd = 3'b011;
          ALU8H:   execWord.wd = 3'b010;
          default: begin
            execWord.wd  = 3'b001;
            execWord.op8 = 1'b1;
          end
        endcase
      end
      MEM: begin
        case (memOp)
          read16, read8L, read8H, read8SignExt: begin
            execWord.ra      = ir[8:6];
            execWord.rb      = ir[5:3];
            execWord.rd      = ir[2:0];
            execWord.addrSel = ir[5:3];
            execNext         = holdUntil(done, finish);
            case (memOp)
              read16: begin
                execWord.rd16 = 1'b1;
                execWord.wd   = 3'b011;
              end
              read8L: begin
                execWord.rd8 = 1'b1;
                execWord.wd  = 3'b001;
              end
              read8H: begin
                execWord.rd8 = 1'b1;
                execWord.wd  = 3'b110;
              end
              default: begin
                execWord.rd8     = 1'b1;
                execWord.wd      = 3'b011;
                execWord.dataSel = 3'd5;  // Sign-extended byte
              end
            endcase
          end
          write16, write8L, write8H: begin
            execWord.rb      = ir[5:3];
            execWord.ra      = ir[2:0];
            execWord.dataSel = 3'd3;
            execWord.addrSel = ir[8:6];
            execNext         = holdUntil(done, finish);
            case (memOp)
              write16: execWord.wr = 2'b11;
              write8L: execWord.wr = 2'b01;
              default: execWord.wr = 2'b10;
            endcase
          end
          loadImmSext: begin
            execWord.rd      = {2'b00, ir[8]};
            execWord.wd      = 3'b011;
            execWord.dataSel = 3'd7;
          end
          loadImm8, loadImm9, loadImm10, loadImm11,
          loadImm12, loadImm13, loadImm14, loadImm15: begin
            execWord.rd      = ir[10:8];
            execWord.wd      = {1'b0, ir[11], ~ir[11]};
            execWord.dataSel = 3'd6;  // Immediate byte
          end
          default: execNext = finish;
        endcase
      end
      JUMP: begin
        execWord.flagCond = minorOp;
        if (ir[8]) begin  // Call
          if (status) begin
            execWord.wr      = 2'b11;
            execWord.trapSel = regTarget ? 3'd0 : 3'd7;
            execWord.dataSel = 3'd2;  // Return address
            execWord.addrSel = 3'd5;  // Stack
            execWord.decSp   = done;
            execNext         = holdUntil(done, toCallTarget);
          end
        end else if (status && !regTarget) begin
          execWord.rd16  = 1'b1;
          execWord.ldPc  = done;
          execNext       = holdUntil(done, finish);
        end else if (status) begin
          execWord.ra      = ir[7:5];
          execWord.dataSel = 3'd3;
          execWord.ldPc    = 1'b1;
        end else begin
          execWord.incPc = 1'b1;  // Skip the target word
        end
      end
      SPECIAL: begin
        case (minorOp)
          4'd0: begin  // Load SP
            if (ir[8]) begin
              execWord.ldSp    = 1'b1;
              execWord.dataSel = 3'd7;
            end else begin
              execWord.rd16  = 1'b1;
              execWord.ldSp  = done;
              execWord.incPc = done;
              execNext       = holdUntil(done, finish);
            end
          end
          4'd1: begin  // Set Flag
            setIrqEn   = 1'b1;
            irqEnValue = ir[8];
          end
          4'd14: begin
            execWord.flagCond = ir[7:4];
            if (status) begin
              execWord.incSp = 1'b1;
              execNext       = toPopPcReti;
            end
          end
          4'd15: begin
            execWord.flagCond = ir[7:4];
            if (status) begin
              execWord.incSp = 1'b1;
              execNext       = toPopPc;
            end
          end
          default: execNext = finish;
        endcase
      end
      default: execNext = finish;  // RSV5, RSV6
    endcase
  end

endmodule

// File: irqArbiter.sv
`include "ctrl_defines.svh"

module irqArbiter (
  input  logic               clk,
  input  logic               rst,
  input  ctrlPkg::irqLines_t irqReq,
  input  logic               setIrqEn,
  input  logic               irqEnValue,
  input  logic               ackStrobe,
  output logic               pending,
  output logic [`SEL_W-1:0]  vectorCode,
  output ctrlPkg::irqLines_t irqAck
);
  import ctrlPkg::*;

  logic irqEn;
  logic intrLive;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      irqEn <= 1'b0;
    end else if (setIrqEn) begin
      irqEn <= irqEnValue;
    end
  end

  assign intrLive = irqReq.intr & irqEn;  // Maskable only when enabled
  assign pending  = irqReq.trap | irqReq.nmi | intrLive;

  // Trap over NMI over maskable
  always_comb begin
    irqAck     = '0;
    vectorCode = 3'd0;
    if (irqReq.trap) begin
      vectorCode  = 3'd1;
      irqAck.trap = ackStrobe;
    end else if (irqReq.nmi) begin
      vectorCode = 3'd2;
      irqAck.nmi = ackStrobe;
    end else if (intrLive) begin
      vectorCode  = 3'd3;
      irqAck.intr = ackStrobe;
    end
  end

endmodule

// File: cpuSequencer.sv
`include "ctrl_defines.svh"

module cpuSequencer (
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] ir,
  input  logic                done,
  input  ctrlPkg::ctrlWord_t  execWord,
  input  ctrlPkg::execNext_e  execNext,
  input  logic                setIrqEn,
  input  logic                pending,
  input  logic [`SEL_W-1:0]   vectorCode,
  output ctrlPkg::ctrlWord_t  ctrl,
  output logic                ackStrobe,
  output logic                irqEnWrite
);
  import ctrlPkg::*;

  seqState_e state;
  seqState_e nextState;
  logic      regTarget;

  assign regTarget  = &ir[`INSTR_W-4 -: `ALUOP_W];
  assign irqEnWrite = setIrqEn && (state == execute);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= fetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    ctrl      = '0;
    nextState = state;
    ackStrobe = 1'b0;
    case (state)
      fetch: begin
        ctrl.rd16  = 1'b1;
        ctrl.ldIr  = 1'b1;
        ctrl.incPc = done;
        nextState  = done ? execute : fetch;
      end
      execute: begin
        ctrl = execWord;
        case (execNext)
          stay:         nextState = execute;
          toCallTarget: nextState = callTarget;
          toPopPc:      nextState = popPc;
          toPopPcReti:  nextState = popPcReti;
          default:      nextState = irqCheck;
        endcase
      end
      callTarget: begin
        if (!regTarget) begin  // Target word follows the call
          ctrl.rd16 = 1'b1;
          ctrl.ldPc = done;
          nextState = done ? irqCheck : callTarget;
        end else begin
          ctrl.ra      = ir[7:5];
          ctrl.dataSel = 3'd3;
          ctrl.ldPc    = 1'b1;
          nextState    = irqCheck;
        end
      end
      popPc: begin
        ctrl.rd16    = 1'b1;
        ctrl.ldPc    = done;
        ctrl.addrSel = 3'd5;
        nextState    = done ? irqCheck : popPc;
      end
      popPcReti: begin
        ctrl.rd16    = 1'b1;
        ctrl.ldPc    = done;
        ctrl.incSp   = done;  // Step up to the saved flags
        ctrl.addrSel = 3'd5;
        nextState    = done ? popFlags : popPcReti;
      end
      popFlags: begin
        ctrl.rd16     = 1'b1;
        ctrl.flagRest = done;
        ctrl.addrSel  = 3'd5;
        nextState     = done ? irqCheck : popFlags;
      end
      irqCheck: begin
        if (pending) begin  // Flags go first
          ctrl.wr      = 2'b11;
          ctrl.dataSel = 3'd4;
          ctrl.addrSel = 3'd5;
          ctrl.decSp   = done;
          nextState    = done ? pushPc : irqCheck;
        end else begin
          nextState = fetch;
        end
      end
      pushPc: begin
        ctrl.wr      = 2'b11;
        ctrl.dataSel = 3'd2;
        ctrl.addrSel = 3'd5;
        ctrl.decSp   = done;
        nextState    = done ? vectorSel : pushPc;
      end
      vectorSel: begin
        ctrl.dataSel = 3'd2;
        ctrl.addrSel = 3'd5;
        ctrl.trapSel = vectorCode;
        nextState    = vectorLoad;
      end
      vectorLoad: begin
        ctrl.ldPc    = 1'b1;
        ctrl.dataSel = 3'd2;
        ctrl.addrSel = 3'd5;
        ctrl.trapSel = vectorCode;
        ackStrobe    = 1'b1;
        nextState    = fetch;
      end
      default: nextState = fetch;
    endcase
  end

endmodule

// File: controller.sv
`include "ctrl_defines.svh"

module controller (
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] ir,
  input  logic                status,
  input  logic                done,
  input  ctrlPkg::irqLines_t  irqReq,
  output ctrlPkg::ctrlWord_t  ctrl,
  output ctrlPkg::irqLines_t  irqAck
);
  import ctrlPkg::*;

  ctrlWord_t         execWord;
  execNext_e         execNext;
  logic              setIrqEn;
  logic              irqEnValue;
  logic              irqEnWrite;
  logic              pending;
  logic              ackStrobe;
  logic [`SEL_W-1:0] vectorCode;

  execDecoder uDecoder (
    .ir         (ir),
    .status     (status),
    .done       (done),
    .execWord   (execWord),
    .execNext   (execNext),
    .setIrqEn   (setIrqEn),
    .irqEnValue (irqEnValue)
  );

  irqArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .irqReq     (irqReq),
    .setIrqEn   (irqEnWrite),  // Only from a real execute cycle
    .irqEnValue (irqEnValue),
    .ackStrobe  (ackStrobe),
    .pending    (pending),
    .vectorCode (vectorCode),
    .irqAck     (irqAck)
  );

  cpuSequencer uSequencer (
    .clk        (clk),
    .rst        (rst),
    .ir         (ir),
    .done       (done),
    .execWord   (execWord),
    .execNext   (execNext),
    .setIrqEn   (setIrqEn),
    .pending    (pending),
    .vectorCode (vectorCode),
    .ctrl       (ctrl),
    .ackStrobe  (ackStrobe),
    .irqEnWrite (irqEnWrite)
  );

endmodule

// File: controller_props.sv
module controller_props (
  input logic               clk,
  input logic               rst,
  input ctrlPkg::ctrlWord_t ctrl,
  input ctrlPkg::irqLines_t irqAck
);
  timeunit 1ns;
  timeprecision 100ps;

  int assertFails = 0;

  oneAckAtATime: assert property (@(posedge clk) disable iff (!rst) $onehot0(irqAck))
    else begin
      assertFails++;
      $error("more than one acknowledge bit high: %b", irqAck);
    end

  // Vector load is the only ack cycle
  ackWithPcLoad: assert property (@(posedge clk) disable iff (!rst) (|irqAck) |-> ctrl.ldPc)
    else begin
      assertFails++;
      $error("acknowledge %b without ldPc", irqAck);
    end

  noWriteWithRead: assert property (@(posedge clk) disable iff (!rst)
                                    (|ctrl.wr) |-> !(ctrl.rd16 || ctrl.rd8))
    else begin
      assertFails++;
      $error("write %b together with a read strobe", ctrl.wr);
    end

  noAckInReset: assert property (@(posedge clk) !rst |-> (irqAck == '0))
    else begin
      assertFails++;
      $error("acknowledge %b while reset is asserted", irqAck);
    end

endmodule

// File: controller_tb.sv
`include "ctrl_defines.svh"

module controller_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ctrlPkg::*;

  localparam int    resetCycles = 4;
  localparam int    slackCycles = 20;
  localparam string stimFile    = "controller_input.txt";

  // One cycle of stimulus and the response expected in it
  typedef struct packed {
    logic [`INSTR_W-1:0] ir;
    logic                status;
    logic                done;
    irqLines_t           irqReq;
    ctrlWord_t           expCtrl;
    irqLines_t           expAck;
  } stimRow_t;

  logic                clk;
  logic                rst;
  logic [`INSTR_W-1:0] ir;
  logic                status;
  logic                done;
  irqLines_t           irqReq;
  ctrlWord_t           ctrl;
  irqLines_t           irqAck;

  stimRow_t rows[$];
  int       errorCount = 0;
  int       rowIndex   = 0;
  int       cycleLimit = 0;
  bit       loaded     = 1'b0;

  controller DUT (
    .clk    (clk),
    .rst    (rst),
    .ir     (ir),
    .status (status),
    .done   (done),
    .irqReq (irqReq),
    .ctrl   (ctrl),
    .irqAck (irqAck)
  );

  bind controller controller_props uProps (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .irqAck (irqAck)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  task automatic compareValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR row %0d %s: expected 0x%0h, actual 0x%0h",
               rowIndex, name, expected, actual);
    end
  endtask

  task automatic loadStimulus();
    int                fd;
    int                n;
    logic [8*256-1:0]  skipped;
    logic [15:0]       vIr, vStatus, vDone, vIrq;
    logic [15:0]       vStrobes, vWr, vAddr, vData, vTrap;
    logic [15:0]       vRa, vRb, vRd, vWd, vAlu, vCond, vFlags, vAck;
    stimRow_t          row;
    fd = $fopen(stimFile, "r");
    if (fd == 0) begin
      errorCount++;
      $display("could not open %s for reading", stimFile);
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                  vIr, vStatus, vDone, vIrq, vStrobes, vWr, vAddr, vData, vTrap,
                  vRa, vRb, vRd, vWd, vAlu, vCond, vFlags, vAck);
      if (n == 17) begin
        row        = '0;
        row.ir     = vIr;
        row.status = vStatus[0];
        row.done   = vDone[0];
        row.irqReq = vIrq[2:0];
        {row.expCtrl.ldIr, row.expCtrl.ldSp, row.expCtrl.incSp, row.expCtrl.decSp,
         row.expCtrl.ldPc, row.expCtrl.incPc, row.expCtrl.rd16,
         row.expCtrl.rd8} = vStrobes[7:0];
        row.expCtrl.wr       = vWr[1:0];
        row.expCtrl.addrSel  = vAddr[`SEL_W-1:0];
        row.expCtrl.dataSel  = vData[`SEL_W-1:0];
        row.expCtrl.trapSel  = vTrap[`SEL_W-1:0];
        row.expCtrl.ra       = vRa[`SEL_W-1:0];
        row.expCtrl.rb       = vRb[`SEL_W-1:0];
        row.expCtrl.rd       = vRd[`SEL_W-1:0];
        row.expCtrl.wd       = vWd[`SEL_W-1:0];
        row.expCtrl.aluop    = vAlu[`ALUOP_W-1:0];
        row.expCtrl.flagCond = vCond[`ALUOP_W-1:0];
        {row.expCtrl.flagSave, row.expCtrl.flagRest, row.expCtrl.op8} = vFlags[2:0];
        row.expAck = vAck[2:0];
        rows.push_back(row);
      end else if (n <= 0) begin
        void'($fgets(skipped, fd));  // Comment line
      end else begin
        errorCount++;
        $display("stimulus line with only %0d of 17 columns in %s", n, stimFile);
        void'($fgets(skipped, fd));
      end
    end
    $fclose(fd);
  endtask

  task automatic checkOutputs(input stimRow_t row);
    compareValue("ctrl.ldIr", row.expCtrl.ldIr, ctrl.ldIr);
    compareValue("ctrl.ldSp", row.expCtrl.ldSp, ctrl.ldSp);
    compareValue("ctrl.incSp", row.expCtrl.incSp, ctrl.incSp);
    compareValue("ctrl.decSp", row.expCtrl.decSp, ctrl.decSp);
    compareValue("ctrl.ldPc", row.expCtrl.ldPc, ctrl.ldPc);
    compareValue("ctrl.incPc", row.expCtrl.incPc, ctrl.incPc);
    compareValue("ctrl.rd16", row.expCtrl.rd16, ctrl.rd16);
    compareValue("ctrl.rd8", row.expCtrl.rd8, ctrl.rd8);
    compareValue("ctrl.wr", row.expCtrl.wr, ctrl.wr);
    compareValue("ctrl.addrSel", row.expCtrl.addrSel, ctrl.addrSel);
    compareValue("ctrl.dataSel", row.expCtrl.dataSel, ctrl.dataSel);
    compareValue("ctrl.trapSel", row.expCtrl.trapSel, ctrl.trapSel);
    compareValue("ctrl.ra", row.expCtrl.ra, ctrl.ra);
    compareValue("ctrl.rb", row.expCtrl.rb, ctrl.rb);
    compareValue("ctrl.rd", row.expCtrl.rd, ctrl.rd);
    compareValue("ctrl.wd", row.expCtrl.wd, ctrl.wd);
    compareValue("ctrl.aluop", row.expCtrl.aluop, ctrl.aluop);
    compareValue("ctrl.flagCond", row.expCtrl.flagCond, ctrl.flagCond);
    compareValue("ctrl.flagSave", row.expCtrl.flagSave, ctrl.flagSave);
    compareValue("ctrl.flagRest", row.expCtrl.flagRest, ctrl.flagRest);
    compareValue("ctrl.op8", row.expCtrl.op8, ctrl.op8);
    compareValue("irqAck", row.expAck, irqAck);
  endtask

  initial begin
    rst    = 1'b0;
    ir     = '0;
    status = 1'b0;
    done   = 1'b0;
    irqReq = '1;  // Every request line raised through reset
    loadStimulus();
    cycleLimit = rows.size() + resetCycles + slackCycles;
    loaded     = 1'b1;
    if (rows.size() == 0) begin
      errorCount++;
      $display("no stimulus rows found in %s", stimFile);
    end
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk);
      rowIndex = i + 1;
      ir     <= rows[i].ir;
      status <= rows[i].status;
      done   <= rows[i].done;
      irqReq <= rows[i].irqReq;
      @(negedge clk);  // Outputs settled mid-cycle
      checkOutputs(rows[i]);
    end
    @(posedge clk);  // Let the last cycle's assertions fire
    #1;
    $display("rows %0d, compare errors %0d, assertion failures %0d",
             rows.size(), errorCount, DUT.uProps.assertFails);
    if (errorCount == 0 && DUT.uProps.assertFails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int cycles;
    cycles = 0;
    wait (loaded);
    while (cycles <= cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the stimulus run did not complete", cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: controller_input.txt
# ir status done irqReq(trap nmi intr) | strobes(ldIr ldSp incSp decSp ldPc incPc rd16 rd8)
# wr addrSel dataSel trapSel ra rb rd wd aluop flagCond flags(flagSave flagRest op8) irqAck
# fetch stalled by done, then ALU16, ALU8H, ALU8L
0453 0 0 0 82 0 0 0 0 0 0 0 0 0 0 0 0
0453 0 0 0 82 0 0 0 0 0 0 0 0 0 0 0 0
0453 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
0453 0 0 0 00 0 0 1 0 1 2 3 3 2 0 4 0
0453 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
2B2E 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
2B2E 0 0 0 00 0 0 1 0 4 5 6 2 5 0 4 0
2B2E 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
4FC1 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
4FC1 0 0 0 00 0 0 1 0 7 0 1 1 7 0 5 0
4FC1 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
# read16 with a wait, write8H, read8SignExt, immediate byte load
6053 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
6053 0 0 0 02 0 2 0 0 1 2 3 3 0 0 0 0
6053 0 1 0 02 0 2 0 0 1 2 3 3 0 0 0 0
6053 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
6B2E 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
6B2E 0 1 0 00 2 4 3 0 6 5 0 0 0 0 0 0
6B2E 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
6C53 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
6C53 0 1 0 01 0 2 5 0 1 2 3 3 0 0 0 0
6C53 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
755A 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
755A 0 0 0 00 0 0 6 0 0 0 5 1 0 0 0 0
755A 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
# jumps: taken to memory target, register target, not taken
8600 1 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
8600 1 0 0 02 0 0 0 0 0 0 0 0 0 3 0 0
8600 1 1 0 0A 0 0 0 0 0 0 0 0 0 3 0 0
8600 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
9EA0 1 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
9EA0 1 0 0 08 0 0 3 0 5 0 0 0 0 F 0 0
9EA0 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
8600 0 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
8600 0 0 0 04 0 0 0 0 0 0 0 0 0 3 0 0
8600 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
# call, return, return from interrupt
8500 1 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
8500 1 0 0 00 3 5 2 7 0 0 0 0 0 2 0 0
8500 1 1 0 10 3 5 2 7 0 0 0 0 0 2 0 0
8500 1 0 0 02 0 0 0 0 0 0 0 0 0 0 0 0
8500 1 1 0 0A 0 0 0 0 0 0 0 0 0 0 0 0
8500 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
FE60 1 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
FE60 1 0 0 20 0 0 0 0 0 0 0 0 0 6 0 0
FE60 1 0 0 02 0 5 0 0 0 0 0 0 0 0 0 0
FE60 1 1 0 0A 0 5 0 0 0 0 0 0 0 0 0 0
FE60 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
FC10 1 1 0 86 0 0 0 0 0 0 0 0 0 0 0 0
FC10 1 0 0 20 0 0 0 0 0 0 0 0 0 1 0 0
FC10 1 1 0 2A 0 5 0 0 0 0 0 0 0 0 0 0
FC10 1 0 0 02 0 5 0 0 0 0 0 0 0 0 0 0
FC10 1 1 0 02 0 5 0 0 0 0 0 0 0 0 2 0
FC10 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0
# Load SP with intr masked, Set Flag, then trap and intr together
E100 0 1 1 86 0 0 0 0 0 0 0 0 0 0 0 0
E100 0 0 1 40 0 0 7 0 0 0 0 0 0 0 0 0
E100 0 0 1 00 0 0 0 0 0 0 0 0 0 0 0 0
E000 0 1 1 86 0 0 0 0 0 0 0 0 0 0 0 0
E000 0 0 1 02 0 0 0 0 0 0 0 0 0 0 0 0
E000 0 1 1 46 0 0 0 0 0 0 0 0 0 0 0 0
E000 0 0 1 00 0 0 0 0 0 0 0 0 0 0 0 0
E300 0 1 1 86 0 0 0 0 0 0 0 0 0 0 0 0
E300 0 0 1 00 0 0 0 0 0 0 0 0 0 0 0 0
E300 0 0 5 00 3 5 4 0 0 0 0 0 0 0 0 0
E300 0 1 5 10 3 5 4 0 0 0 0 0 0 0 0 0
E300 0 1 5 10 3 5 2 0 0 0 0 0 0 0 0 0
E300 0 0 5 00 0 5 2 1 0 0 0 0 0 0 0 0
E300 0 0 5 08 0 5 2 1 0 0 0 0 0 0 0 4
E300 0 0 0 82 0 0 0 0 0 0 0 0 0 0 0 0

// File: flist.f
+incdir+.
ctrlPkg.sv
execDecoder.sv
irqArbiter.sv
cpuSequencer.sv
controller.sv
controller_props.sv
controller_tb.sv

// File: Bender.yml
package:
  name: controller

export_include_dirs:
  - .

sources:
  - ctrlPkg.sv
  - execDecoder.sv
  - irqArbiter.sv
  - cpuSequencer.sv
  - controller.sv
  - target: test
    files:
      - controller_props.sv
      - controller_tb.sv
